//--- tb.f
+incdir+.
mmu_pkg.sv
mmu_tlb.sv
mmu_fetch_xlate.sv
mmu_data_xlate.sv
mmu_top.sv
tb_clk_gen.sv
tb_mmu.sv

//--- Makefile
# Verilator build and run of the MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_mmu.sv
// ------------------------------
// mmu testbench
// directed tests of the Sv39 MMU against a small reference model
// of the TLB, paddr and fault rules
// ------------------------------
`timescale 1ns/10ps
`include "mmu_settings.svh"

module tb_mmu;

  logic                  clk;
  logic                  rst_n;
  mmu_pkg::fetch_req_t   fetch_req;
  mmu_pkg::lsu_req_t     lsu_req;
  mmu_pkg::priv_lvl_e    priv_lvl;
  mmu_pkg::priv_lvl_e    lsu_priv_lvl;
  logic                  sum;
  logic [`MMU_ASIDW-1:0] asid;
  logic                  en_fetch;
  logic                  en_lsu;
  mmu_pkg::tlb_flush_t   flush;
  mmu_pkg::tlb_update_t  itlb_upd;
  mmu_pkg::tlb_update_t  dtlb_upd;
  mmu_pkg::fetch_rsp_t   fetch_rsp;
  mmu_pkg::lsu_rsp_t     lsu_rsp;
  logic                  lsu_dtlb_hit;
  logic                  itlb_miss;
  logic                  dtlb_miss;

  int errors   = 0;
  int checks   = 0;
  int tests    = 0;
  int err_mark = 0;

  tb_clk_gen clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mmu_top UUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .fetch_req_i      (fetch_req),
    .lsu_req_i        (lsu_req),
    .priv_lvl_i       (priv_lvl),
    .lsu_priv_lvl_i   (lsu_priv_lvl),
    .sum_i            (sum),
    .asid_i           (asid),
    .en_fetch_xlate_i (en_fetch),
    .en_lsu_xlate_i   (en_lsu),
    .flush_i          (flush),
    .itlb_update_i    (itlb_upd),
    .dtlb_update_i    (dtlb_upd),
    .fetch_rsp_o      (fetch_rsp),
    .lsu_rsp_o        (lsu_rsp),
    .lsu_dtlb_hit_o   (lsu_dtlb_hit),
    .itlb_miss_o      (itlb_miss),
    .dtlb_miss_o      (dtlb_miss)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  // page offset widens by 9 bits per superpage level
  function automatic logic [`MMU_PLEN-1:0] expect_paddr(input logic [`MMU_PPNW-1:0] ppn,
                                                        input logic [`MMU_VLEN-1:0] va,
                                                        input int level);
    logic [`MMU_PLEN-1:0] mask;
    mask = (56'd1 << (12 + 9 * level)) - 56'd1;
    return ({ppn, 12'h000} & ~mask) | (56'(va) & mask);
  endfunction

  // U/S rule, sum only opens user pages to S-mode data accesses
  function automatic logic page_fault(input logic is_fetch, input logic st,
                                      input mmu_pkg::priv_lvl_e prv, input logic sum_v,
                                      input logic u, input logic w, input logic d);
    logic allowed;
    if (prv == mmu_pkg::PRIV_U) allowed = u;
    else allowed = !u || (sum_v && !is_fetch);
    return !allowed || (st && !(w && d));
  endfunction

  function automatic logic [`MMU_XLEN-1:0] sign_extend(input logic [`MMU_VLEN-1:0] va);
    return {{(`MMU_XLEN - `MMU_VLEN){va[`MMU_VLEN-1]}}, va};
  endfunction

  // ------------------------------
  // helpers
  // ------------------------------
  task check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0d ns %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // inputs change 10 ns after the rising edge
  task step;
    @(posedge clk);
    #10;
  endtask

  task end_test(input string name);
    tests++;
    $display("%-22s %s (%0d errors)", name, (errors == err_mark) ? "ok" : "FAILED",
             errors - err_mark);
    err_mark = errors;
  endtask

  // same refill into both TLBs, a/x/r/v always set
  task refill(input logic is_2m, input logic is_1g, input logic [`MMU_VLEN-1:0] va,
              input logic [`MMU_ASIDW-1:0] id, input logic [`MMU_PPNW-1:0] ppn,
              input logic u, input logic w, input logic d);
    itlb_upd = {1'b1, is_2m, is_1g, va[38:12], id, ppn, d, 1'b1, u, 1'b1, w, 1'b1, 1'b1};
    dtlb_upd = itlb_upd;
    step();
    itlb_upd.valid = 1'b0;
    dtlb_upd.valid = 1'b0;
  endtask

  task flush_tlbs(input logic by_asid, input logic [`MMU_ASIDW-1:0] id);
    flush = {1'b1, by_asid, id};
    step();
    flush = '0;
  endtask

  // fetch answers in the same cycle
  task fetch_access(input logic [`MMU_XLEN-1:0] va, input logic hit_e,
                    input logic [`MMU_PLEN-1:0] pa_e, input logic ex_e, input logic [5:0] cause_e);
    fetch_req.req   = 1'b1;
    fetch_req.vaddr = va;
    #20;
    check_val("fetch_rsp_o.valid", 64'(fetch_rsp.valid), 64'(hit_e || ex_e));
    check_val("itlb_miss_o", 64'(itlb_miss), 64'(!hit_e && !ex_e));
    check_val("fetch_rsp_o.ex.valid", 64'(fetch_rsp.ex.valid), 64'(ex_e));
    if (ex_e) begin
      check_val("fetch_rsp_o.ex.cause", 64'(fetch_rsp.ex.cause), 64'(cause_e));
      check_val("fetch_rsp_o.ex.tval", fetch_rsp.ex.tval, va);
    end else if (hit_e) begin
      check_val("fetch_rsp_o.paddr", 64'(fetch_rsp.paddr), 64'(pa_e));
    end
    step();
    fetch_req.req = 1'b0;
  endtask

  // hit in the request cycle, response in the next one
  task lsu_access(input logic [`MMU_VLEN-1:0] va, input logic st, input logic hit_e,
                  input logic [`MMU_PLEN-1:0] pa_e, input logic ex_e);
    int lat;
    lsu_req.req      = 1'b1;
    lsu_req.vaddr    = va;
    lsu_req.is_store = st;
    #20;
    check_val("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit), 64'(hit_e));
    step();
    lsu_req.req = 1'b0;
    #20;
    lat = 1;
    while (!lsu_rsp.valid && !dtlb_miss && lat < 8) begin
      step();
      #20;
      lat++;
    end
    if (lat >= 8) $display("no load/store response or miss within 8 cycles for %h", va);
    check_val("lsu latency", 64'(lat), 64'd1);
    check_val("lsu_rsp_o.valid", 64'(lsu_rsp.valid), 64'(hit_e));
    check_val("dtlb_miss_o", 64'(dtlb_miss), 64'(!hit_e));
    check_val("lsu_rsp_o.ex.valid", 64'(lsu_rsp.ex.valid), 64'(hit_e && ex_e));
    if (hit_e && ex_e) begin
      check_val("lsu_rsp_o.ex.cause", 64'(lsu_rsp.ex.cause),
                st ? 64'(mmu_pkg::CAUSE_STORE_PAGE) : 64'(mmu_pkg::CAUSE_LOAD_PAGE));
      check_val("lsu_rsp_o.ex.tval", lsu_rsp.ex.tval, sign_extend(va));
    end else if (hit_e) begin
      check_val("lsu_rsp_o.paddr", 64'(lsu_rsp.paddr), 64'(pa_e));
    end
    step();
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task bare_mode;
    logic [`MMU_VLEN-1:0] va;
    va       = `MMU_VLEN'({$urandom, $urandom});
    en_fetch = 1'b0;
    en_lsu   = 1'b0;
    fetch_access(64'(va), 1'b1, 56'(va), 1'b0, 6'd0);
    lsu_access(va, 1'b0, 1'b1, 56'(va), 1'b0);
    end_test("bare_mode");
  endtask

  task miss_then_refill;
    logic [`MMU_VLEN-1:0] va;
    logic [`MMU_PPNW-1:0] ppn;
    va       = {9'h005, 30'($urandom)};
    ppn      = `MMU_PPNW'({$urandom, $urandom});
    en_fetch = 1'b1;
    en_lsu   = 1'b1;
    asid     = 4'd3;
    flush_tlbs(1'b0, 4'd0);
    fetch_access(sign_extend(va), 1'b0, '0, 1'b0, 6'd0);
    lsu_access(va, 1'b0, 1'b0, '0, 1'b0);
    refill(1'b0, 1'b0, va, 4'd3, ppn, 1'b0, 1'b1, 1'b1);
    fetch_access(sign_extend(va), 1'b1, expect_paddr(ppn, va, 0), 1'b0, 6'd0);
    lsu_access(va, 1'b0, 1'b1, expect_paddr(ppn, va, 0), 1'b0);
    end_test("miss_then_refill");
  endtask

  task superpages;
    logic [`MMU_VLEN-1:0] va2, va1, alt2, alt1;
    logic [`MMU_PPNW-1:0] ppn2, ppn1;
    va2  = {9'h011, 30'($urandom)};
    va1  = {9'h022, 30'($urandom)};
    ppn2 = `MMU_PPNW'({$urandom, $urandom});
    ppn1 = `MMU_PPNW'({$urandom, $urandom});
    refill(1'b1, 1'b0, va2, asid, ppn2, 1'b0, 1'b1, 1'b1);
    refill(1'b0, 1'b1, va1, asid, ppn1, 1'b0, 1'b1, 1'b1);
    // other vpn bits inside the same superpage
    alt2 = va2 ^ {18'h0, 9'($urandom), 12'h0};
    alt1 = va1 ^ {9'h0, 18'($urandom), 12'h0};
    fetch_access(sign_extend(alt2), 1'b1, expect_paddr(ppn2, alt2, 1), 1'b0, 6'd0);
    fetch_access(sign_extend(alt1), 1'b1, expect_paddr(ppn1, alt1, 2), 1'b0, 6'd0);
    lsu_access(alt2, 1'b0, 1'b1, expect_paddr(ppn2, alt2, 1), 1'b0);
    lsu_access(alt1, 1'b0, 1'b1, expect_paddr(ppn1, alt1, 2), 1'b0);
    end_test("superpages");
  endtask

  task permission_faults;
    logic [`MMU_VLEN-1:0] va_u, va_r, va_c;
    logic [`MMU_PPNW-1:0] ppn;
    va_u = {9'h041, 30'($urandom)};
    va_r = {9'h042, 30'($urandom)};
    va_c = {9'h043, 30'($urandom)};
    ppn  = `MMU_PPNW'({$urandom, $urandom});
    flush_tlbs(1'b0, 4'd0);
    // user page, read-only supervisor page, clean supervisor page
    refill(1'b0, 1'b0, va_u, asid, ppn, 1'b1, 1'b1, 1'b1);
    refill(1'b0, 1'b0, va_r, asid, ppn, 1'b0, 1'b0, 1'b1);
    refill(1'b0, 1'b0, va_c, asid, ppn, 1'b0, 1'b1, 1'b0);
    fetch_access(sign_extend(va_u), 1'b1, expect_paddr(ppn, va_u, 0),
                 page_fault(1'b1, 1'b0, priv_lvl, sum, 1'b1, 1'b1, 1'b1),
                 mmu_pkg::CAUSE_INSTR_PAGE);
    lsu_priv_lvl = mmu_pkg::PRIV_U;
    lsu_access(va_r, 1'b0, 1'b1, expect_paddr(ppn, va_r, 0),
               page_fault(1'b0, 1'b0, lsu_priv_lvl, sum, 1'b0, 1'b0, 1'b1));
    lsu_priv_lvl = mmu_pkg::PRIV_S;
    for (int s = 0; s < 2; s++) begin
      sum = s[0];
      lsu_access(va_u, 1'b0, 1'b1, expect_paddr(ppn, va_u, 0),
                 page_fault(1'b0, 1'b0, lsu_priv_lvl, sum, 1'b1, 1'b1, 1'b1));
    end
    sum = 1'b0;
    lsu_access(va_r, 1'b1, 1'b1, expect_paddr(ppn, va_r, 0),
               page_fault(1'b0, 1'b1, lsu_priv_lvl, sum, 1'b0, 1'b0, 1'b1));
    lsu_access(va_c, 1'b1, 1'b1, expect_paddr(ppn, va_c, 0),
               page_fault(1'b0, 1'b1, lsu_priv_lvl, sum, 1'b0, 1'b1, 1'b0));
    end_test("permission_faults");
  endtask

  task flushes;
    logic [`MMU_VLEN-1:0] va_a, va_b;
    logic [`MMU_PPNW-1:0] ppn;
    va_a = {9'h031, 30'($urandom)};
    va_b = {9'h032, 30'($urandom)};
    ppn  = `MMU_PPNW'({$urandom, $urandom});
    flush_tlbs(1'b0, 4'd0);
    refill(1'b0, 1'b0, va_a, 4'd1, ppn, 1'b0, 1'b1, 1'b1);
    refill(1'b0, 1'b0, va_b, 4'd2, ppn, 1'b0, 1'b1, 1'b1);
    asid = 4'd1;
    lsu_access(va_a, 1'b0, 1'b1, expect_paddr(ppn, va_a, 0), 1'b0);
    // asid 1 goes, asid 2 stays
    flush_tlbs(1'b1, 4'd1);
    lsu_access(va_a, 1'b0, 1'b0, '0, 1'b0);
    fetch_access(sign_extend(va_a), 1'b0, '0, 1'b0, 6'd0);
    asid = 4'd2;
    lsu_access(va_b, 1'b0, 1'b1, expect_paddr(ppn, va_b, 0), 1'b0);
    flush_tlbs(1'b0, 4'd0);
    lsu_access(va_b, 1'b0, 1'b0, '0, 1'b0);
    end_test("flushes");
  endtask

  task canonical_and_pipeline;
    logic [`MMU_VLEN-1:0] va_p, va_q;
    logic [`MMU_PPNW-1:0] ppn;
    va_p = {9'h051, 30'($urandom)};
    va_q = {va_p[38:12], 12'($urandom)};
    ppn  = `MMU_PPNW'({$urandom, $urandom});
    // bit 40 set, bit 38 clear
    fetch_access(64'h0000_0100_0000_1000, 1'b0, '0, 1'b1, mmu_pkg::CAUSE_INSTR_ACCESS);
    refill(1'b0, 1'b0, va_p, asid, ppn, 1'b0, 1'b1, 1'b1);
    lsu_req = {1'b1, va_p, 1'b0};
    step();
    // second load issued while the first one answers
    lsu_req.vaddr = va_q;
    #20;
    check_val("lsu_rsp_o.valid", 64'(lsu_rsp.valid), 64'd1);
    check_val("lsu_rsp_o.paddr", 64'(lsu_rsp.paddr), 64'(expect_paddr(ppn, va_p, 0)));
    step();
    lsu_req.req = 1'b0;
    #20;
    check_val("lsu_rsp_o.valid", 64'(lsu_rsp.valid), 64'd1);
    check_val("lsu_rsp_o.paddr", 64'(lsu_rsp.paddr), 64'(expect_paddr(ppn, va_q, 0)));
    step();
    end_test("canonical_and_pipeline");
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int n;
    void'($urandom(63));
    fetch_req    = '0;
    lsu_req      = '0;
    priv_lvl     = mmu_pkg::PRIV_S;
    lsu_priv_lvl = mmu_pkg::PRIV_S;
    sum          = 1'b0;
    asid         = '0;
    en_fetch     = 1'b0;
    en_lsu       = 1'b0;
    flush        = '0;
    itlb_upd     = '0;
    dtlb_upd     = '0;
    n            = 0;
    while (!rst_n && n < 20) begin
      step();
      n++;
    end
    if (!rst_n) begin
      $display("reset was not released within 20 cycles");
      errors++;
    end
    // outputs idle after reset
    check_val("fetch_rsp_o.valid", 64'(fetch_rsp.valid), 64'd0);
    check_val("lsu_rsp_o.valid", 64'(lsu_rsp.valid), 64'd0);
    check_val("itlb_miss_o", 64'(itlb_miss), 64'd0);
    check_val("dtlb_miss_o", 64'(dtlb_miss), 64'd0);
    bare_mode();
    miss_then_refill();
    superpages();
    permission_faults();
    flushes();
    canonical_and_pipeline();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
// ------------------------------
// testbench clock and reset
// free-running clock, active-low reset held for a few cycles
// ------------------------------
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

  // release away from the stimulus slot at 10 ns after the edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #(PERIOD / 20);
    rst_no = 1'b1;
  end

endmodule

//--- mmu_top.sv
// ------------------------------
// mmu top
// Sv39 MMU with one ITLB and one DTLB feeding the fetch and
// load/store translation paths
// ------------------------------
`timescale 1ns/10ps
`include "mmu_settings.svh"

module mmu_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mmu_pkg::fetch_req_t   fetch_req_i,
  input  mmu_pkg::lsu_req_t     lsu_req_i,
  input  mmu_pkg::priv_lvl_e    priv_lvl_i,
  input  mmu_pkg::priv_lvl_e    lsu_priv_lvl_i,
  input  logic                  sum_i,
  input  logic [`MMU_ASIDW-1:0] asid_i,
  input  logic                  en_fetch_xlate_i,
  input  logic                  en_lsu_xlate_i,
  input  mmu_pkg::tlb_flush_t   flush_i,
  input  mmu_pkg::tlb_update_t  itlb_update_i,
  input  mmu_pkg::tlb_update_t  dtlb_update_i,
  output mmu_pkg::fetch_rsp_t   fetch_rsp_o,
  output mmu_pkg::lsu_rsp_t     lsu_rsp_o,
  output logic                  lsu_dtlb_hit_o,
  output logic                  itlb_miss_o,
  output logic                  dtlb_miss_o
);

  // instruction side TLB result
  logic          itlb_hit;
  mmu_pkg::pte_t itlb_pte;
  logic          itlb_is_2m;
  logic          itlb_is_1g;

  // data side TLB result
  logic          dtlb_hit;
  mmu_pkg::pte_t dtlb_pte;
  logic          dtlb_is_2m;
  logic          dtlb_is_1g;

  mmu_tlb #(
    .ENTRIES (`MMU_ITLB_ENTRIES)
  ) i_itlb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .update_i    (itlb_update_i),
    .lu_access_i (fetch_req_i.req),
    .lu_asid_i   (asid_i),
    .lu_vaddr_i  (fetch_req_i.vaddr[`MMU_VLEN-1:0]),
    .lu_hit_o    (itlb_hit),
    .lu_pte_o    (itlb_pte),
    .lu_is_2m_o  (itlb_is_2m),
    .lu_is_1g_o  (itlb_is_1g)
  );

  mmu_tlb #(
    .ENTRIES (`MMU_DTLB_ENTRIES)
  ) i_dtlb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .update_i    (dtlb_update_i),
    .lu_access_i (lsu_req_i.req),
    .lu_asid_i   (asid_i),
    .lu_vaddr_i  (lsu_req_i.vaddr),
    .lu_hit_o    (dtlb_hit),
    .lu_pte_o    (dtlb_pte),
    .lu_is_2m_o  (dtlb_is_2m),
    .lu_is_1g_o  (dtlb_is_1g)
  );

  mmu_fetch_xlate i_fetch (
    .fetch_req_i (fetch_req_i),
    .en_xlate_i  (en_fetch_xlate_i),
    .priv_lvl_i  (priv_lvl_i),
    .tlb_hit_i   (itlb_hit),
    .tlb_pte_i   (itlb_pte),
    .tlb_is_2m_i (itlb_is_2m),
    .tlb_is_1g_i (itlb_is_1g),
    .fetch_rsp_o (fetch_rsp_o),
    .itlb_miss_o (itlb_miss_o)
  );

  mmu_data_xlate i_data (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_req_i   (lsu_req_i),
    .en_xlate_i  (en_lsu_xlate_i),
    .priv_lvl_i  (lsu_priv_lvl_i),
    .sum_i       (sum_i),
    .tlb_hit_i   (dtlb_hit),
    .tlb_pte_i   (dtlb_pte),
    .tlb_is_2m_i (dtlb_is_2m),
    .tlb_is_1g_i (dtlb_is_1g),
    .dtlb_hit_o  (lsu_dtlb_hit_o),
    .lsu_rsp_o   (lsu_rsp_o),
    .dtlb_miss_o (dtlb_miss_o)
  );

endmodule

//--- mmu_data_xlate.sv
// ------------------------------
// load/store translation
// hit in the request cycle, paddr and page faults one cycle later
// ------------------------------
`timescale 1ns/10ps
`include "mmu_settings.svh"

module mmu_data_xlate (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mmu_pkg::lsu_req_t  lsu_req_i,
  input  logic               en_xlate_i,
  input  mmu_pkg::priv_lvl_e priv_lvl_i,
  input  logic               sum_i,
  input  logic               tlb_hit_i,
  input  mmu_pkg::pte_t      tlb_pte_i,
  input  logic               tlb_is_2m_i,
  input  logic               tlb_is_1g_i,
  output logic               dtlb_hit_o,
  output mmu_pkg::lsu_rsp_t  lsu_rsp_o,
  output logic               dtlb_miss_o
);

  // request payload captured with the TLB result
  typedef struct packed {
    logic [`MMU_VLEN-1:0] vaddr;
    logic                 is_store;
    mmu_pkg::pte_t        pte;
    logic                 is_2m;
    logic                 is_1g;
  } stage_t;

  stage_t               stage_q;
  logic                 req_q;
  logic                 hit_q;
  logic                 access_err;
  logic [`MMU_XLEN-1:0] tval;

  // ------------------------------
  // cycle 0
  // ------------------------------
  // always a hit in bare mode
  assign dtlb_hit_o = en_xlate_i ? tlb_hit_i : 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i.req;
      hit_q <= tlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    stage_q <= {lsu_req_i.vaddr, lsu_req_i.is_store, tlb_pte_i, tlb_is_2m_i, tlb_is_1g_i};
  end

  // ------------------------------
  // cycle 1
  // ------------------------------
  // S mode needs sum for user pages, U mode needs the u bit
  assign access_err = ((priv_lvl_i == mmu_pkg::PRIV_S) && !sum_i && stage_q.pte.u) ||
                      ((priv_lvl_i == mmu_pkg::PRIV_U) && !stage_q.pte.u);

  // trap value is the sign-extended vaddr
  assign tval = {{(`MMU_XLEN - `MMU_VLEN){stage_q.vaddr[`MMU_VLEN-1]}}, stage_q.vaddr};

  always_comb begin
    lsu_rsp_o       = '0;
    lsu_rsp_o.valid = req_q;
    lsu_rsp_o.paddr = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, stage_q.vaddr};
    dtlb_miss_o     = 1'b0;

    if (en_xlate_i) begin
      lsu_rsp_o.valid = req_q && hit_q;
      lsu_rsp_o.paddr = mmu_pkg::pte_paddr(stage_q.pte.ppn, stage_q.vaddr[29:0],
                                           stage_q.is_2m, stage_q.is_1g);
      dtlb_miss_o     = req_q && !hit_q;
      if (req_q && hit_q) begin
        if (stage_q.is_store) begin
          // store also needs a writable, dirty page
          if (!stage_q.pte.w || !stage_q.pte.d || access_err) begin
            lsu_rsp_o.ex.cause = mmu_pkg::CAUSE_STORE_PAGE;
            lsu_rsp_o.ex.tval  = tval;
            lsu_rsp_o.ex.valid = 1'b1;
          end
        end else if (access_err) begin
          lsu_rsp_o.ex.cause = mmu_pkg::CAUSE_LOAD_PAGE;
          lsu_rsp_o.ex.tval  = tval;
          lsu_rsp_o.ex.valid = 1'b1;
        end
      end
    end
  end

endmodule

//--- mmu_fetch_xlate.sv
// ------------------------------
// fetch translation
// same-cycle instruction address translation with canonical
// check and U/S page fault
// ------------------------------
`timescale 1ns/10ps
`include "mmu_settings.svh"

module mmu_fetch_xlate (
  input  mmu_pkg::fetch_req_t fetch_req_i,
  input  logic                en_xlate_i,
  input  mmu_pkg::priv_lvl_e  priv_lvl_i,
  input  logic                tlb_hit_i,
  input  mmu_pkg::pte_t       tlb_pte_i,
  input  logic                tlb_is_2m_i,
  input  logic                tlb_is_1g_i,
  output mmu_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                itlb_miss_o
);

  logic canonical;
  logic u_err;

  // Sv39 needs bits 63..38 to be a sign extension of bit 38
  assign canonical = (&fetch_req_i.vaddr[`MMU_XLEN-1:`MMU_VLEN-1]) ||
                     !(|fetch_req_i.vaddr[`MMU_XLEN-1:`MMU_VLEN-1]);

  // user page from S mode or supervisor page from U mode
  assign u_err = ((priv_lvl_i == mmu_pkg::PRIV_U) && !tlb_pte_i.u) ||
                 ((priv_lvl_i == mmu_pkg::PRIV_S) && tlb_pte_i.u);

  always_comb begin
    // bare mode passes the address through
    fetch_rsp_o       = '0;
    fetch_rsp_o.valid = fetch_req_i.req;
    fetch_rsp_o.paddr = fetch_req_i.vaddr[`MMU_PLEN-1:0];
    itlb_miss_o       = 1'b0;

    if (en_xlate_i) begin
      fetch_rsp_o.valid = 1'b0;
      fetch_rsp_o.paddr = mmu_pkg::pte_paddr(tlb_pte_i.ppn, fetch_req_i.vaddr[29:0],
                                             tlb_is_2m_i, tlb_is_1g_i);
      // canonical fault has priority over the TLB result
      if (fetch_req_i.req && !canonical) begin
        fetch_rsp_o.valid    = 1'b1;
        fetch_rsp_o.ex.cause = mmu_pkg::CAUSE_INSTR_ACCESS;
        fetch_rsp_o.ex.tval  = fetch_req_i.vaddr;
        fetch_rsp_o.ex.valid = 1'b1;
      end else if (tlb_hit_i) begin
        fetch_rsp_o.valid = fetch_req_i.req;
        if (u_err) begin
          fetch_rsp_o.ex.cause = mmu_pkg::CAUSE_INSTR_PAGE;
          fetch_rsp_o.ex.tval  = fetch_req_i.vaddr;
          fetch_rsp_o.ex.valid = fetch_req_i.req;
        end
      end else begin
        // miss, the walker refills through the update port
        itlb_miss_o = fetch_req_i.req;
      end
    end
  end

endmodule

//--- mmu_tlb.sv
// ------------------------------
// mmu tlb
// fully associative TLB with 4K/2M/1G matching, full or per-ASID
// flush and round-robin refill into a full array
// ------------------------------
`timescale 1ns/10ps
`include "mmu_settings.svh"

module mmu_tlb #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mmu_pkg::tlb_flush_t   flush_i,
  input  mmu_pkg::tlb_update_t  update_i,
  input  logic                  lu_access_i,
  input  logic [`MMU_ASIDW-1:0] lu_asid_i,
  input  logic [`MMU_VLEN-1:0]  lu_vaddr_i,
  output logic                  lu_hit_o,
  output mmu_pkg::pte_t         lu_pte_o,
  output logic                  lu_is_2m_o,
  output logic                  lu_is_1g_o
);

  localparam int unsigned IDXW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // per-entry tag
  typedef struct packed {
    logic [`MMU_VPNW-1:0]  vpn;
    logic [`MMU_ASIDW-1:0] asid;
    logic                  is_2m;
    logic                  is_1g;
  } tag_t;

  tag_t               tag_q [ENTRIES];
  mmu_pkg::pte_t      pte_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q, valid_d, valid_flushed, hit;
  logic [IDXW-1:0]    rr_q, rr_d, victim;
  logic [`MMU_VPNW-1:0] lu_vpn;
  logic               full;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:12];

  // ------------------------------
  // lookup
  // ------------------------------
  // vpn[17:0] ignored for 1G, vpn[8:0] ignored for 2M
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      hit[i] = valid_q[i] && (tag_q[i].asid == lu_asid_i) &&
               (tag_q[i].vpn[26:18] == lu_vpn[26:18]) &&
               (tag_q[i].is_1g || ((tag_q[i].vpn[17:9] == lu_vpn[17:9]) &&
               (tag_q[i].is_2m || (tag_q[i].vpn[8:0] == lu_vpn[8:0]))));
    end
  end

  always_comb begin
    lu_hit_o   = 1'b0;
    lu_pte_o   = '0;
    lu_is_2m_o = 1'b0;
    lu_is_1g_o = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (hit[i]) begin
        lu_hit_o   = lu_access_i;
        lu_pte_o   = pte_q[i];
        lu_is_2m_o = tag_q[i].is_2m;
        lu_is_1g_o = tag_q[i].is_1g;
      end
    end
  end

  // ------------------------------
  // flush and refill
  // ------------------------------
  always_comb begin
    // flush acts first, a refill in the same cycle survives it
    valid_flushed = valid_q;
    if (flush_i.valid) begin
      for (int i = 0; i < ENTRIES; i++) begin
        if (!flush_i.by_asid || (tag_q[i].asid == flush_i.asid)) begin
          valid_flushed[i] = 1'b0;
        end
      end
    end
    full = &valid_flushed;
    // lowest free slot, else the round-robin slot
    victim = rr_q;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (!valid_flushed[i]) begin
        victim = IDXW'(i);
      end
    end
    valid_d = valid_flushed;
    rr_d    = rr_q;
    if (update_i.valid) begin
      valid_d[victim] = 1'b1;
      if (full) begin
        rr_d = (rr_q == IDXW'(ENTRIES - 1)) ? '0 : rr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else begin
      valid_q <= valid_d;
      rr_q    <= rr_d;
    end
  end

  // tag and pte arrays
  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      tag_q[victim] <= {update_i.vpn, update_i.asid, update_i.is_2m, update_i.is_1g};
      pte_q[victim] <= update_i.pte;
    end
  end

endmodule

//--- mmu_pkg.sv
// ------------------------------
// mmu package
// PTE, refill, flush, trap and request/response types of the MMU,
// the trap cause codes and the physical address helper
// ------------------------------
`include "mmu_settings.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01
  } priv_lvl_e;

  // leaf page-table entry as kept in the TLB
  typedef struct packed {
    logic [`MMU_PPNW-1:0] ppn;
    logic                 d;
    logic                 a;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 v;
  } pte_t;

  // refill from the external walker
  typedef struct packed {
    logic                  valid;
    logic                  is_2m;
    logic                  is_1g;
    logic [`MMU_VPNW-1:0]  vpn;
    logic [`MMU_ASIDW-1:0] asid;
    pte_t                  pte;
  } tlb_update_t;

  // flush all entries or only one address space
  typedef struct packed {
    logic                  valid;
    logic                  by_asid;
    logic [`MMU_ASIDW-1:0] asid;
  } tlb_flush_t;

  typedef struct packed {
    logic [5:0]           cause;
    logic [`MMU_XLEN-1:0] tval;
    logic                 valid;
  } exception_t;

  // fetch vaddr is full xlen so the canonical check can see the upper bits
  typedef struct packed {
    logic                 req;
    logic [`MMU_XLEN-1:0] vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`MMU_PLEN-1:0] paddr;
    exception_t           ex;
  } fetch_rsp_t;

  typedef struct packed {
    logic                 req;
    logic [`MMU_VLEN-1:0] vaddr;
    logic                 is_store;
  } lsu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`MMU_PLEN-1:0] paddr;
    exception_t           ex;
  } lsu_rsp_t;

  // trap causes
  localparam logic [5:0] CAUSE_INSTR_ACCESS = 6'd1;
  localparam logic [5:0] CAUSE_INSTR_PAGE   = 6'd12;
  localparam logic [5:0] CAUSE_LOAD_PAGE    = 6'd13;
  localparam logic [5:0] CAUSE_STORE_PAGE   = 6'd15;

  // ppn plus page offset, superpages take the low vpn bits from the vaddr
  function automatic logic [`MMU_PLEN-1:0] pte_paddr(
    logic [`MMU_PPNW-1:0] ppn,
    logic [29:0]          voff,
    logic                 is_2m,
    logic                 is_1g
  );
    logic [`MMU_PLEN-1:0] pa;
    pa = {ppn, voff[11:0]};
    if (is_2m) begin
      pa[20:12] = voff[20:12];
    end
    if (is_1g) begin
      pa[29:12] = voff[29:12];
    end
    return pa;
  endfunction

endpackage

//--- mmu_settings.svh
// ------------------------------
// mmu settings
// address widths, TLB sizes and ASID width of the Sv39 MMU
// ------------------------------
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Sv39 virtual address
`define MMU_VLEN 39
// physical address and page number
`define MMU_PLEN 56
`define MMU_PPNW 44
// three 9-bit vpn levels
`define MMU_VPNW 27

// address space identifier
`define MMU_ASIDW 4

// fully associative TLB sizes
`define MMU_ITLB_ENTRIES 4
`define MMU_DTLB_ENTRIES 4

// trap value width
`define MMU_XLEN 64

`endif
